/* src/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Datapath
`define XLEN 32
`define REG_COUNT 32
`define REG_INDEX_W 5

// Management address map
`define MGMT_ADDR_W 16
`define MGMT_PC_SET 16'h0000
`define MGMT_PC_JUMP 16'h0004
`define MGMT_PC_STEP 16'h0008
`define MGMT_INSTR 16'h0010
`define MGMT_REG_BASE 16'h4000

// Sticky error code
`define ERR_W 4
`define ERR_INVALID 0
`define ERR_MISALIGNED 1

`endif

/* src/rvPkg.sv */
package rvPkg;

	typedef enum logic [6:0] {
		opLui = 7'b0110111,
		opAuipc = 7'b0010111,
		opJal = 7'b1101111,
		opJalr = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad = 7'b0000011,
		opStore = 7'b0100011,
		opImm = 7'b0010011,
		opReg = 7'b0110011,
		opFence = 7'b0001111
	} opcodeT;

	// One instruction word seen through each RV32I format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rType;
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} iType;
		struct packed {
			logic [6:0] immHi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [6:0] opcode;
		} sType;
		struct packed {
			logic imm12;
			logic [5:0] imm10to5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4to1;
			logic imm11;
			logic [6:0] opcode;
		} bType;
		struct packed {
			logic [19:0] imm;
			logic [4:0] rd;
			logic [6:0] opcode;
		} uType;
		struct packed {
			logic imm20;
			logic [9:0] imm10to1;
			logic imm11;
			logic [7:0] imm19to12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} jType;
	} instrWord;

	typedef enum logic [1:0] {
		halt = 2'b00,
		fetch = 2'b10,
		execute = 2'b11
	} coreState;

endpackage

/* src/instrDecoder.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module instrDecoder (
	input rvPkg::instrWord instruction,
	output logic [`REG_INDEX_W-1:0] rdIndex,
	output logic [`REG_INDEX_W-1:0] rs1Index,
	output logic [`REG_INDEX_W-1:0] rs2Index,
	output logic [2:0] funct3,
	output logic [`XLEN-1:0] immediate,
	output logic isLui,
	output logic isAuipc,
	output logic isJal,
	output logic isJalr,
	output logic isBranch,
	output logic isLoad,
	output logic isStore,
	output logic isAluImm,
	output logic isAluReg,
	output logic isFence,
	output logic aluAlt,
	output logic invalidInstruction
);

	rvPkg::opcodeT opcode;
	logic [6:0] funct7;
	logic isShiftImm;
	logic [9:0] classes;

	assign opcode = rvPkg::opcodeT'(instruction.rType.opcode);
	assign funct7 = instruction.rType.funct7;
	assign funct3 = instruction.rType.funct3;
	assign rdIndex = instruction.rType.rd;
	assign rs1Index = instruction.rType.rs1;
	assign rs2Index = instruction.rType.rs2;

	always_comb begin
		case (opcode)
			rvPkg::opLui, rvPkg::opAuipc:
				immediate = {instruction.uType.imm, 12'h000};
			rvPkg::opJal:
				immediate = {{12{instruction.jType.imm20}}, instruction.jType.imm19to12,
					instruction.jType.imm11, instruction.jType.imm10to1, 1'b0};
			rvPkg::opBranch:
				immediate = {{20{instruction.bType.imm12}}, instruction.bType.imm11,
					instruction.bType.imm10to5, instruction.bType.imm4to1, 1'b0};
			rvPkg::opStore:
				immediate = {{20{instruction.sType.immHi[6]}}, instruction.sType.immHi,
					instruction.sType.immLo};
			default:
				immediate = {{20{instruction.iType.imm[11]}}, instruction.iType.imm};
		endcase
	end

	assign isLui = opcode == rvPkg::opLui;
	assign isAuipc = opcode == rvPkg::opAuipc;
	assign isJal = opcode == rvPkg::opJal;
	assign isJalr = opcode == rvPkg::opJalr && funct3 == 3'b000;
	// funct3 010 and 011 are not branches
	assign isBranch = opcode == rvPkg::opBranch && funct3[2:1] != 2'b01;
	assign isLoad = opcode == rvPkg::opLoad && funct3 != 3'b011 && funct3[2:1] != 2'b11;
	assign isStore = opcode == rvPkg::opStore && funct3[2] == 1'b0 && funct3 != 3'b011;

	assign isShiftImm = (funct3 == 3'b001 && funct7 == 7'b0000000)
		|| (funct3 == 3'b101 && (funct7 == 7'b0000000 || funct7 == 7'b0100000));
	assign isAluImm = opcode == rvPkg::opImm
		&& ((funct3 != 3'b001 && funct3 != 3'b101) || isShiftImm);
	assign isAluReg = opcode == rvPkg::opReg && (funct7 == 7'b0000000
		|| (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
	assign isFence = opcode == rvPkg::opFence && funct3 == 3'b000;

	// SUB and SRA/SRAI only
	assign aluAlt = funct7 == 7'b0100000
		&& (isAluReg || (opcode == rvPkg::opImm && isShiftImm));

	assign classes = {isLui, isAuipc, isJal, isJalr, isBranch,
		isLoad, isStore, isAluImm, isAluReg, isFence};
	assign invalidInstruction = !$onehot(classes);

endmodule

/* src/aluUnit.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module aluUnit (
	input logic [`XLEN-1:0] programCounter,
	input logic [`XLEN-1:0] rs1Data,
	input logic [`XLEN-1:0] rs2Data,
	input logic [`XLEN-1:0] immediate,
	input logic [2:0] funct3,
	input logic isAuipc,
	input logic isAluImm,
	input logic isLoad,
	input logic isStore,
	input logic isBranch,
	input logic isJal,
	input logic isJalr,
	input logic aluAlt,
	output logic [`XLEN-1:0] sum,
	output logic [`XLEN-1:0] aluResult,
	output logic takeBranch,
	output logic [`XLEN-1:0] nextProgramCounter
);

	logic [`XLEN-1:0] operandA;
	logic [`XLEN-1:0] operandB;
	logic [`XLEN:0] difference;
	logic equal;
	logic lessThan;
	logic lessThanUnsigned;
	logic isLeftShift;
	logic [`XLEN-1:0] shiftInput;
	logic [`XLEN:0] shifted;
	logic [`XLEN-1:0] rightShift;
	logic [`XLEN-1:0] leftShift;
	logic branchCondition;
	logic [`XLEN-1:0] targetBase;
	logic [`XLEN-1:0] target;

	assign operandA = isAuipc ? programCounter : rs1Data;
	assign operandB = (isAuipc || isAluImm || isLoad || isStore) ? immediate : rs2Data;

	assign sum = operandA + operandB;

	// Compare through one subtraction with a borrow bit
	assign difference = {1'b0, operandA} - {1'b0, operandB};
	assign equal = difference[`XLEN-1:0] == '0;
	assign lessThanUnsigned = difference[`XLEN];
	assign lessThan = (operandA[`XLEN-1] ^ operandB[`XLEN-1])
		? operandA[`XLEN-1] : difference[`XLEN];

	// Left shift reuses the right shifter on reversed bits
	assign isLeftShift = funct3 == 3'b001;
	assign shiftInput = isLeftShift ? {<<{operandA}} : operandA;
	assign shifted = $signed({aluAlt && shiftInput[`XLEN-1] && !isLeftShift, shiftInput})
		>>> operandB[4:0];
	assign rightShift = shifted[`XLEN-1:0];
	assign leftShift = {<<{rightShift}};

	always_comb begin
		case (funct3)
			3'b000: aluResult = aluAlt ? difference[`XLEN-1:0] : sum;
			3'b001: aluResult = leftShift;
			3'b010: aluResult = {{(`XLEN-1){1'b0}}, lessThan};
			3'b011: aluResult = {{(`XLEN-1){1'b0}}, lessThanUnsigned};
			3'b100: aluResult = operandA ^ operandB;
			3'b101: aluResult = rightShift;
			3'b110: aluResult = operandA | operandB;
			default: aluResult = operandA & operandB;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000: branchCondition = equal;
			3'b001: branchCondition = !equal;
			3'b100: branchCondition = lessThan;
			3'b101: branchCondition = !lessThan;
			3'b110: branchCondition = lessThanUnsigned;
			3'b111: branchCondition = !lessThanUnsigned;
			default: branchCondition = 1'b0;
		endcase
	end

	assign takeBranch = isBranch && branchCondition;

	assign targetBase = isJalr ? rs1Data : programCounter;
	assign target = (isJal || isJalr || takeBranch)
		? targetBase + immediate : programCounter + `XLEN'd4;
	assign nextProgramCounter = {target[`XLEN-1:1], 1'b0};

endmodule

/* src/loadStoreUnit.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module loadStoreUnit (
	input rvPkg::coreState state,
	input logic [`XLEN-1:0] programCounter,
	input logic [`XLEN-1:0] address,
	input logic [2:0] funct3,
	input logic isLoad,
	input logic isStore,
	input logic [`XLEN-1:0] storeData,
	input logic [`XLEN-1:0] memoryDataRead,
	input logic memoryBusy,
	output logic [`XLEN-1:0] memoryAddress,
	output logic [3:0] memoryByteSelect,
	output logic memoryReadEnable,
	output logic memoryWriteEnable,
	output logic [`XLEN-1:0] memoryDataWrite,
	output logic [`XLEN-1:0] loadData,
	output logic misaligned,
	output logic memoryDone
);

	logic inFetch;
	logic inExecute;
	logic [`XLEN-1:0] targetAddress;
	logic [1:0] laneOffset;
	logic [3:0] baseMask;
	logic [6:0] byteMask;
	logic doLoad;
	logic doStore;
	logic [`XLEN-1:0] laneData;

	assign inFetch = state == rvPkg::fetch;
	assign inExecute = state == rvPkg::execute;

	// Fetch always reads the whole word holding the PC
	assign targetAddress = inFetch ? programCounter : address;
	assign laneOffset = inFetch ? 2'b00 : address[1:0];

	always_comb begin
		case (funct3[1:0])
			2'b00: baseMask = 4'b0001;
			2'b01: baseMask = 4'b0011;
			2'b10: baseMask = 4'b1111;
			default: baseMask = 4'b0000;
		endcase
		if (inFetch)
			baseMask = 4'b1111;
	end

	assign byteMask = {3'b000, baseMask} << laneOffset;
	// Bytes pushed past lane 3 cross into the next word
	assign misaligned = inExecute && (isLoad || isStore) && |byteMask[6:4];

	assign doLoad = inFetch || (inExecute && isLoad && !misaligned);
	assign doStore = inExecute && isStore && !misaligned;

	assign memoryReadEnable = doLoad;
	assign memoryWriteEnable = doStore;
	assign memoryAddress = (doLoad || doStore) ? {targetAddress[`XLEN-1:2], 2'b00} : '0;
	assign memoryByteSelect = (doLoad || doStore) ? byteMask[3:0] : 4'b0000;
	assign memoryDataWrite = doStore ? storeData << {laneOffset, 3'b000} : '0;
	assign memoryDone = (doLoad || doStore) && !memoryBusy;

	assign laneData = memoryDataRead >> {laneOffset, 3'b000};

	always_comb begin
		case (funct3)
			3'b000: loadData = {{24{laneData[7]}}, laneData[7:0]};
			3'b001: loadData = {{16{laneData[15]}}, laneData[15:0]};
			3'b100: loadData = {24'h000000, laneData[7:0]};
			3'b101: loadData = {16'h0000, laneData[15:0]};
			default: loadData = laneData;
		endcase
		if (inFetch)
			loadData = memoryDataRead;
	end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module regFile (
	input logic clk,
	input logic [`REG_INDEX_W-1:0] rs1Index,
	input logic [`REG_INDEX_W-1:0] rs2Index,
	input logic [`REG_INDEX_W-1:0] mgmtIndex,
	input logic writeEnable,
	input logic [`REG_INDEX_W-1:0] writeIndex,
	input logic [`XLEN-1:0] writeData,
	output logic [`XLEN-1:0] rs1Data,
	output logic [`XLEN-1:0] rs2Data,
	output logic [`XLEN-1:0] mgmtData
);

	// x0 has no storage
	logic [`XLEN-1:0] registers [1:`REG_COUNT-1];

	assign rs1Data = (rs1Index == '0) ? '0 : registers[rs1Index];
	assign rs2Data = (rs2Index == '0) ? '0 : registers[rs2Index];
	assign mgmtData = (mgmtIndex == '0) ? '0 : registers[mgmtIndex];

	always_ff @(posedge clk) begin
		if (writeEnable && writeIndex != '0)
			registers[writeIndex] <= writeData;
	end

endmodule

/* src/coreControl.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module coreControl (
	input logic clk,
	input logic rst,
	input logic managementRun,
	input logic managementWriteEnable,
	input logic [`MGMT_ADDR_W-1:0] managementAddress,
	input logic [`XLEN-1:0] managementWriteData,
	input logic isLui,
	input logic isAuipc,
	input logic isJal,
	input logic isJalr,
	input logic isLoad,
	input logic isStore,
	input logic isAluImm,
	input logic isAluReg,
	input logic invalidInstruction,
	input logic [`REG_INDEX_W-1:0] rdIndex,
	input logic [`XLEN-1:0] immediate,
	input logic [`XLEN-1:0] sum,
	input logic [`XLEN-1:0] aluResult,
	input logic [`XLEN-1:0] nextProgramCounter,
	input logic [`XLEN-1:0] loadData,
	input logic [`XLEN-1:0] mgmtData,
	input logic misaligned,
	input logic memoryDone,
	output rvPkg::coreState state,
	output logic [`XLEN-1:0] programCounter,
	output rvPkg::instrWord instruction,
	output logic regWriteEnable,
	output logic [`REG_INDEX_W-1:0] regWriteIndex,
	output logic [`XLEN-1:0] regWriteData,
	output logic [`REG_INDEX_W-1:0] mgmtIndex,
	output logic [`XLEN-1:0] managementReadData,
	output logic [`ERR_W-1:0] errorCode
);

	logic [`MGMT_ADDR_W-1:0] regOffset;
	logic selectRegister;
	logic writeValid;
	logic pcSetWrite;
	logic pcJumpWrite;
	logic stepWrite;
	logic regMgmtWrite;
	logic [`XLEN-1:0] jumpTarget;
	logic noError;
	logic fault;
	logic progress;
	logic writesRd;
	logic completeExecute;
	logic [`XLEN-1:0] writeBackData;

	// Register window is 32 words starting at the base
	assign regOffset = managementAddress - `MGMT_REG_BASE;
	assign selectRegister = regOffset < `MGMT_ADDR_W'(4 * `REG_COUNT) && regOffset[1:0] == 2'b00;
	assign mgmtIndex = regOffset[`REG_INDEX_W+1:2];

	assign writeValid = !managementRun && managementWriteEnable;
	assign pcSetWrite = writeValid && managementAddress == `MGMT_PC_SET;
	assign pcJumpWrite = writeValid && managementAddress == `MGMT_PC_JUMP;
	assign stepWrite = writeValid && managementAddress == `MGMT_PC_STEP;
	assign regMgmtWrite = writeValid && selectRegister;
	assign jumpTarget = programCounter + managementWriteData;

	always_comb begin
		managementReadData = '0;
		if (!managementRun) begin
			if (managementAddress == `MGMT_PC_SET)
				managementReadData = programCounter;
			else if (managementAddress == `MGMT_INSTR)
				managementReadData = instruction;
			else if (selectRegister)
				managementReadData = mgmtData;
		end
	end

	assign noError = errorCode == '0;
	assign fault = invalidInstruction || misaligned;
	assign progress = (isLoad || isStore) ? memoryDone : 1'b1;
	assign writesRd = isLui || isAuipc || isJal || isJalr || isAluImm || isAluReg || isLoad;
	assign completeExecute = noError && state == rvPkg::execute && !fault && progress;

	always_comb begin
		if (isLui)
			writeBackData = immediate;
		else if (isAuipc)
			writeBackData = sum;
		else if (isJal || isJalr)
			writeBackData = programCounter + `XLEN'd4;
		else if (isLoad)
			writeBackData = loadData;
		else
			writeBackData = aluResult;
	end

	// Management writes share the port while halted
	assign regWriteEnable = (noError && state == rvPkg::halt && regMgmtWrite)
		|| (completeExecute && writesRd);
	assign regWriteIndex = (state == rvPkg::halt) ? mgmtIndex : rdIndex;
	assign regWriteData = (state == rvPkg::halt) ? managementWriteData : writeBackData;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rvPkg::halt;
			programCounter <= '0;
			errorCode <= '0;
		end else if (noError) begin
			case (state)
				rvPkg::halt: begin
					if (managementRun || stepWrite)
						state <= rvPkg::fetch;
					else if (pcSetWrite)
						programCounter <= {managementWriteData[`XLEN-1:1], 1'b0};
					else if (pcJumpWrite)
						programCounter <= {jumpTarget[`XLEN-1:1], 1'b0};
				end
				rvPkg::fetch: begin
					if (memoryDone)
						state <= rvPkg::execute;
				end
				rvPkg::execute: begin
					if (fault) begin
						errorCode[`ERR_INVALID] <= invalidInstruction;
						errorCode[`ERR_MISALIGNED] <= misaligned;
					end else if (progress) begin
						programCounter <= nextProgramCounter;
						state <= managementRun ? rvPkg::fetch : rvPkg::halt;
					end
				end
				default: state <= rvPkg::halt;
			endcase
		end
	end

	// Instruction latch
	always_ff @(posedge clk) begin
		if (noError && state == rvPkg::fetch && memoryDone)
			instruction <= loadData;
	end

endmodule

/* src/rv32Core.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv32Core (
	input logic clk,
	input logic rst,
	output logic [`XLEN-1:0] memoryAddress,
	output logic [3:0] memoryByteSelect,
	output logic memoryReadEnable,
	output logic memoryWriteEnable,
	output logic [`XLEN-1:0] memoryDataWrite,
	input logic [`XLEN-1:0] memoryDataRead,
	input logic memoryBusy,
	input logic managementRun,
	input logic managementWriteEnable,
	input logic [`MGMT_ADDR_W-1:0] managementAddress,
	input logic [`XLEN-1:0] managementWriteData,
	output logic [`XLEN-1:0] managementReadData,
	output logic [`ERR_W-1:0] errorCode
);

	rvPkg::coreState state;
	rvPkg::instrWord instruction;
	logic [`XLEN-1:0] programCounter;
	logic [`REG_INDEX_W-1:0] rdIndex;
	logic [`REG_INDEX_W-1:0] rs1Index;
	logic [`REG_INDEX_W-1:0] rs2Index;
	logic [`REG_INDEX_W-1:0] mgmtIndex;
	logic [`REG_INDEX_W-1:0] regWriteIndex;
	logic [2:0] funct3;
	logic [`XLEN-1:0] immediate;
	logic isLui;
	logic isAuipc;
	logic isJal;
	logic isJalr;
	logic isBranch;
	logic isLoad;
	logic isStore;
	logic isAluImm;
	logic isAluReg;
	logic aluAlt;
	logic invalidInstruction;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;
	logic [`XLEN-1:0] mgmtData;
	logic regWriteEnable;
	logic [`XLEN-1:0] regWriteData;
	logic [`XLEN-1:0] sum;
	logic [`XLEN-1:0] aluResult;
	logic [`XLEN-1:0] nextProgramCounter;
	logic [`XLEN-1:0] loadData;
	logic misaligned;
	logic memoryDone;

	coreControl control_i (
		.clk(clk),
		.rst(rst),
		.managementRun(managementRun),
		.managementWriteEnable(managementWriteEnable),
		.managementAddress(managementAddress),
		.managementWriteData(managementWriteData),
		.isLui(isLui),
		.isAuipc(isAuipc),
		.isJal(isJal),
		.isJalr(isJalr),
		.isLoad(isLoad),
		.isStore(isStore),
		.isAluImm(isAluImm),
		.isAluReg(isAluReg),
		.invalidInstruction(invalidInstruction),
		.rdIndex(rdIndex),
		.immediate(immediate),
		.sum(sum),
		.aluResult(aluResult),
		.nextProgramCounter(nextProgramCounter),
		.loadData(loadData),
		.mgmtData(mgmtData),
		.misaligned(misaligned),
		.memoryDone(memoryDone),
		.state(state),
		.programCounter(programCounter),
		.instruction(instruction),
		.regWriteEnable(regWriteEnable),
		.regWriteIndex(regWriteIndex),
		.regWriteData(regWriteData),
		.mgmtIndex(mgmtIndex),
		.managementReadData(managementReadData),
		.errorCode(errorCode)
	);

	instrDecoder decoder_i (
		.instruction(instruction),
		.rdIndex(rdIndex),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.funct3(funct3),
		.immediate(immediate),
		.isLui(isLui),
		.isAuipc(isAuipc),
		.isJal(isJal),
		.isJalr(isJalr),
		.isBranch(isBranch),
		.isLoad(isLoad),
		.isStore(isStore),
		.isAluImm(isAluImm),
		.isAluReg(isAluReg),
		.isFence(),
		.aluAlt(aluAlt),
		.invalidInstruction(invalidInstruction)
	);

	regFile regs_i (
		.clk(clk),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.mgmtIndex(mgmtIndex),
		.writeEnable(regWriteEnable),
		.writeIndex(regWriteIndex),
		.writeData(regWriteData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.mgmtData(mgmtData)
	);

	aluUnit alu_i (
		.programCounter(programCounter),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.immediate(immediate),
		.funct3(funct3),
		.isAuipc(isAuipc),
		.isAluImm(isAluImm),
		.isLoad(isLoad),
		.isStore(isStore),
		.isBranch(isBranch),
		.isJal(isJal),
		.isJalr(isJalr),
		.aluAlt(aluAlt),
		.sum(sum),
		.aluResult(aluResult),
		.takeBranch(),
		.nextProgramCounter(nextProgramCounter)
	);

	loadStoreUnit lsu_i (
		.state(state),
		.programCounter(programCounter),
		.address(sum),
		.funct3(funct3),
		.isLoad(isLoad),
		.isStore(isStore),
		.storeData(rs2Data),
		.memoryDataRead(memoryDataRead),
		.memoryBusy(memoryBusy),
		.memoryAddress(memoryAddress),
		.memoryByteSelect(memoryByteSelect),
		.memoryReadEnable(memoryReadEnable),
		.memoryWriteEnable(memoryWriteEnable),
		.memoryDataWrite(memoryDataWrite),
		.loadData(loadData),
		.misaligned(misaligned),
		.memoryDone(memoryDone)
	);

endmodule

/* verification/rv32Core_assertions.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv32Core_assertions (
	input logic clk,
	input logic rst,
	input logic memoryReadEnable,
	input logic memoryWriteEnable,
	input logic [3:0] memoryByteSelect,
	input logic [`ERR_W-1:0] errorCode
);

	enablesExclusive: assert property (@(posedge clk) disable iff (rst)
		!(memoryReadEnable && memoryWriteEnable))
		else $error("memory read and write enables high together");

	byteSelectActive: assert property (@(posedge clk) disable iff (rst)
		(memoryReadEnable || memoryWriteEnable) |-> memoryByteSelect != 4'b0000)
		else $error("memory access with empty byte select");

	// Error code holds until reset
	errorSticky: assert property (@(posedge clk) disable iff (rst)
		errorCode != '0 |=> errorCode == $past(errorCode))
		else $error("errorCode changed without reset");

endmodule

bind rv32Core rv32Core_assertions assertions_i (
	.clk(clk),
	.rst(rst),
	.memoryReadEnable(memoryReadEnable),
	.memoryWriteEnable(memoryWriteEnable),
	.memoryByteSelect(memoryByteSelect),
	.errorCode(errorCode)
);

/* verification/rv32Core_tb.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv32Core_tb;

	localparam logic [31:0] RD_PRESET = 32'h5a5a5a5a;
	localparam logic [31:0] DATA_ADDR = 32'h00000100;
	localparam logic [31:0] LOOP_END = 32'h00000214;

	logic clk;
	logic rst;
	logic [`XLEN-1:0] memoryAddress;
	logic [3:0] memoryByteSelect;
	logic memoryReadEnable;
	logic memoryWriteEnable;
	logic [`XLEN-1:0] memoryDataWrite;
	logic [`XLEN-1:0] memoryDataRead;
	logic memoryBusy;
	logic managementRun;
	logic managementWriteEnable;
	logic [`MGMT_ADDR_W-1:0] managementAddress;
	logic [`XLEN-1:0] managementWriteData;
	logic [`XLEN-1:0] managementReadData;
	logic [`ERR_W-1:0] errorCode;

	logic [31:0] mem [0:255];
	logic [31:0] lfsr;
	int cycles;
	int cycleLimit;
	int checks;
	int errors;
	int selfFetches;
	logic [31:0] entryPc;

	// Stimulus table, one column per queue
	logic [31:0] tInstr[$];
	logic [31:0] tRs1[$];
	logic [31:0] tRs2[$];
	logic [31:0] tPc[$];
	logic [31:0] tMemPreset[$];
	logic [31:0] tExpRd[$];
	logic [31:0] tExpPc[$];
	logic [31:0] tExpMem[$];
	logic [3:0] tExpErr[$];

	rv32Core dut_i (
		.clk(clk),
		.rst(rst),
		.memoryAddress(memoryAddress),
		.memoryByteSelect(memoryByteSelect),
		.memoryReadEnable(memoryReadEnable),
		.memoryWriteEnable(memoryWriteEnable),
		.memoryDataWrite(memoryDataWrite),
		.memoryDataRead(memoryDataRead),
		.memoryBusy(memoryBusy),
		.managementRun(managementRun),
		.managementWriteEnable(managementWriteEnable),
		.managementAddress(managementAddress),
		.managementWriteData(managementWriteData),
		.managementReadData(managementReadData),
		.errorCode(errorCode)
	);

	always #50 clk = !clk;

	function automatic logic nextRandomBit();
		logic outBit;
		outBit = lfsr[0];
		lfsr = lfsr >> 1;
		if (outBit)
			lfsr = lfsr ^ 32'h80200003;
		return outBit;
	endfunction

	// Busy in about one cycle of four
	always @(posedge clk) begin
		#5;
		memoryBusy = nextRandomBit() & nextRandomBit();
	end

	assign memoryDataRead = mem[memoryAddress[9:2]];

	always @(posedge clk) begin
		if (memoryWriteEnable && !memoryBusy) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (memoryByteSelect[lane])
					mem[memoryAddress[9:2]][lane*8 +: 8] <= memoryDataWrite[lane*8 +: 8];
			end
		end
		if (memoryReadEnable && !memoryBusy && memoryAddress == LOOP_END)
			selfFetches <= selfFetches + 1;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// RV32I integer semantics
	function automatic logic [31:0] refAlu(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic addEntry(logic [31:0] instr, logic [31:0] a, logic [31:0] b,
		logic [31:0] memPreset, logic [31:0] expRd, logic [31:0] expPc,
		logic [31:0] expMem, logic [3:0] expErr);
		tInstr.push_back(instr);
		tRs1.push_back(a);
		tRs2.push_back(b);
		tPc.push_back(entryPc);
		tMemPreset.push_back(memPreset);
		tExpRd.push_back(expRd);
		tExpPc.push_back(expPc);
		tExpMem.push_back(expMem);
		tExpErr.push_back(expErr);
		entryPc = entryPc + 4;
	endtask

	task automatic aluCase(logic useImm, logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		logic [11:0] imm;
		logic [31:0] operandB;
		logic [31:0] instr;
		if (useImm) begin
			imm = b[11:0];
			if (f3 == 3'd1 || f3 == 3'd5)
				imm = {alt ? 7'h20 : 7'h00, b[4:0]};
			operandB = {{20{imm[11]}}, imm};
			instr = encI(imm, 5'd1, f3, 5'd3, 7'b0010011);
		end else begin
			operandB = b;
			instr = encR(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3);
		end
		addEntry(instr, a, b, 0, refAlu(f3, alt, a, operandB), entryPc + 4, 0, 0);
	endtask

	task automatic branchCase(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		addEntry(encB(13'd16, 5'd2, 5'd1, f3), a, b, 0, RD_PRESET,
			branchTaken(f3, a, b) ? entryPc + 16 : entryPc + 4, 0, 0);
	endtask

	task automatic buildTable();
		entryPc = 32'h0;
		aluCase(0, 3'd0, 0, 32'h7fffffff, 32'd1);
		aluCase(0, 3'd0, 1, 32'd5, 32'd7);
		aluCase(0, 3'd1, 0, 32'd1, 32'd31);
		aluCase(0, 3'd1, 0, 32'h12345678, 32'd0);
		aluCase(0, 3'd2, 0, 32'hffffffff, 32'd1);
		aluCase(0, 3'd3, 0, 32'hffffffff, 32'd1);
		aluCase(0, 3'd4, 0, 32'hf0f0ff00, 32'h0ff0f0f0);
		aluCase(0, 3'd5, 0, 32'h80000000, 32'd31);
		aluCase(0, 3'd5, 1, 32'h80000000, 32'd4);
		aluCase(0, 3'd6, 0, 32'h00ff0000, 32'h0000ff00);
		aluCase(0, 3'd7, 0, 32'hff00ff00, 32'h0ff00ff0);
		aluCase(1, 3'd0, 0, 32'd10, 32'hffd);
		aluCase(1, 3'd2, 0, 32'hfffffffb, 32'hffc);
		aluCase(1, 3'd3, 0, 32'd1, 32'hfff);
		aluCase(1, 3'd4, 0, 32'h00000f0f, 32'hfff);
		aluCase(1, 3'd6, 0, 32'h80000000, 32'h123);
		aluCase(1, 3'd7, 0, 32'hffffffff, 32'h7f0);
		aluCase(1, 3'd1, 0, 32'd1, 32'd31);
		aluCase(1, 3'd5, 0, 32'hdeadbeef, 32'd0);
		aluCase(1, 3'd5, 1, 32'h80000000, 32'd31);
		branchCase(3'd0, 32'd3, 32'd3);
		branchCase(3'd0, 32'd3, 32'd4);
		branchCase(3'd1, 32'd3, 32'd4);
		branchCase(3'd1, 32'd3, 32'd3);
		branchCase(3'd4, 32'hffffffff, 32'd1);
		branchCase(3'd4, 32'd1, 32'hffffffff);
		branchCase(3'd5, 32'hffffffff, 32'd1);
		branchCase(3'd5, 32'd1, 32'hffffffff);
		branchCase(3'd6, 32'hffffffff, 32'd1);
		branchCase(3'd6, 32'd1, 32'hffffffff);
		branchCase(3'd7, 32'hffffffff, 32'd1);
		branchCase(3'd7, 32'd1, 32'hffffffff);
		addEntry(encJ(21'h40, 5'd3), 0, 0, 0, entryPc + 4, entryPc + 32'h40, 0, 0);
		addEntry(encI(12'd5, 5'd1, 3'd0, 5'd3, 7'b1100111), 32'hc0, 0, 0,
			entryPc + 4, 32'hc4, 0, 0);
		addEntry({20'h12345, 5'd3, 7'b0110111}, 0, 0, 0, 32'h12345000, entryPc + 4, 0, 0);
		addEntry({20'h00001, 5'd3, 7'b0010111}, 0, 0, 0, entryPc + 32'h1000,
			entryPc + 4, 0, 0);
		addEntry(32'h0ff0000f, 0, 0, 0, RD_PRESET, entryPc + 4, 0, 0);
		// Loads from 0x100 holding 80 91 a2 f3
		addEntry(encI(12'd0, 5'd1, 3'd0, 5'd3, 7'b0000011), DATA_ADDR, 0, 32'h8091a2f3,
			32'hfffffff3, entryPc + 4, 32'h8091a2f3, 0);
		addEntry(encI(12'd3, 5'd1, 3'd0, 5'd3, 7'b0000011), DATA_ADDR, 0, 32'h8091a2f3,
			32'hffffff80, entryPc + 4, 32'h8091a2f3, 0);
		addEntry(encI(12'd1, 5'd1, 3'd4, 5'd3, 7'b0000011), DATA_ADDR, 0, 32'h8091a2f3,
			32'h000000a2, entryPc + 4, 32'h8091a2f3, 0);
		addEntry(encI(12'd2, 5'd1, 3'd1, 5'd3, 7'b0000011), DATA_ADDR, 0, 32'h8091a2f3,
			32'hffff8091, entryPc + 4, 32'h8091a2f3, 0);
		addEntry(encI(12'd0, 5'd1, 3'd5, 5'd3, 7'b0000011), DATA_ADDR, 0, 32'h8091a2f3,
			32'h0000a2f3, entryPc + 4, 32'h8091a2f3, 0);
		addEntry(encI(12'd0, 5'd1, 3'd2, 5'd3, 7'b0000011), DATA_ADDR, 0, 32'h8091a2f3,
			32'h8091a2f3, entryPc + 4, 32'h8091a2f3, 0);
		addEntry(encS(12'd1, 5'd2, 5'd1, 3'd0), DATA_ADDR, 32'h11223344, 32'haabbccdd,
			RD_PRESET, entryPc + 4, 32'haabb44dd, 0);
		addEntry(encS(12'd2, 5'd2, 5'd1, 3'd1), DATA_ADDR, 32'h11223344, 32'haabbccdd,
			RD_PRESET, entryPc + 4, 32'h3344ccdd, 0);
		addEntry(encS(12'd0, 5'd2, 5'd1, 3'd2), DATA_ADDR, 32'h11223344, 32'haabbccdd,
			RD_PRESET, entryPc + 4, 32'h11223344, 0);
		// CSR instructions decode as invalid
		addEntry(encI(12'h300, 5'd1, 3'd1, 5'd3, 7'b1110011), 32'd7, 0, 0, RD_PRESET,
			entryPc, 0, 4'd1);
		addEntry(encI(12'd2, 5'd1, 3'd2, 5'd3, 7'b0000011), DATA_ADDR, 0, 32'h01020304,
			RD_PRESET, entryPc, 32'h01020304, 4'd2);
	endtask

	task automatic checkValue(string what, logic [31:0] got, logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic resetCore();
		rst = 1'b1;
		repeat (16) @(posedge clk);
		#5;
		rst = 1'b0;
	endtask

	task automatic mgmtWrite(logic [15:0] addr, logic [31:0] data);
		managementAddress = addr;
		managementWriteData = data;
		managementWriteEnable = 1'b1;
		@(posedge clk);
		#5;
		managementWriteEnable = 1'b0;
	endtask

	task automatic mgmtRead(logic [15:0] addr, output logic [31:0] data);
		managementAddress = addr;
		#1;
		data = managementReadData;
	endtask

	task automatic stepAndWait();
		logic [31:0] pcBefore;
		logic [31:0] pcNow;
		mgmtRead(`MGMT_PC_SET, pcBefore);
		mgmtWrite(`MGMT_PC_STEP, 32'h0);
		managementAddress = `MGMT_PC_SET;
		do begin
			@(posedge clk);
			#5;
			mgmtRead(`MGMT_PC_SET, pcNow);
		end while (pcNow == pcBefore && errorCode == '0);
	endtask

	task automatic mgmtChecks();
		logic [31:0] value;
		mgmtWrite(`MGMT_REG_BASE + 16'd20, 32'h13579bdf);
		mgmtRead(`MGMT_REG_BASE + 16'd20, value);
		checkValue("x5 readback", value, 32'h13579bdf);
		mgmtWrite(`MGMT_REG_BASE, 32'hffffffff);
		mgmtRead(`MGMT_REG_BASE, value);
		checkValue("x0 readback", value, 32'h0);
		mgmtWrite(`MGMT_PC_SET, 32'h41);
		mgmtWrite(`MGMT_PC_JUMP, 32'h20);
		mgmtRead(`MGMT_PC_SET, value);
		checkValue("PC after jump", value, 32'h60);
	endtask

	task automatic runTableEntry(int i);
		logic [31:0] value;
		logic [31:0] pcAfter;
		mgmtWrite(`MGMT_REG_BASE + 16'd4, tRs1[i]);
		mgmtWrite(`MGMT_REG_BASE + 16'd8, tRs2[i]);
		mgmtWrite(`MGMT_REG_BASE + 16'd12, RD_PRESET);
		mgmtWrite(`MGMT_PC_SET, tPc[i]);
		mem[tPc[i][9:2]] = tInstr[i];
		mem[DATA_ADDR[9:2]] = tMemPreset[i];
		stepAndWait();
		mgmtRead(`MGMT_REG_BASE + 16'd12, value);
		checkValue($sformatf("entry %0d rd", i), value, tExpRd[i]);
		mgmtRead(`MGMT_PC_SET, pcAfter);
		checkValue($sformatf("entry %0d PC", i), pcAfter, tExpPc[i]);
		checkValue($sformatf("entry %0d memory", i), mem[DATA_ADDR[9:2]], tExpMem[i]);
		checkValue($sformatf("entry %0d errorCode", i), 32'(errorCode), 32'(tExpErr[i]));
		mgmtRead(`MGMT_INSTR, value);
		checkValue($sformatf("entry %0d instruction register", i), value, tInstr[i]);
		if (tExpErr[i] != 0) begin
			// A frozen core ignores further steps
			mgmtWrite(`MGMT_PC_STEP, 32'h0);
			repeat (8) @(posedge clk);
			#5;
			mgmtRead(`MGMT_PC_SET, value);
			checkValue($sformatf("entry %0d PC after extra step", i), value, pcAfter);
			checkValue($sformatf("entry %0d sticky errorCode", i), 32'(errorCode),
				32'(tExpErr[i]));
			resetCore();
		end
	endtask

	task automatic runLoopProgram();
		logic [31:0] value;
		int quiet;
		mem[128] = encI(12'd0, 5'd0, 3'd0, 5'd3, 7'b0010011);
		mem[129] = encI(12'd5, 5'd0, 3'd0, 5'd1, 7'b0010011);
		mem[130] = encR(7'h00, 5'd1, 5'd3, 3'd0, 5'd3);
		mem[131] = encI(12'hfff, 5'd1, 3'd0, 5'd1, 7'b0010011);
		mem[132] = encB(-13'sd8, 5'd0, 5'd1, 3'd1);
		mem[133] = encJ(21'd0, 5'd0);
		mgmtWrite(`MGMT_PC_SET, 32'h200);
		selfFetches = 0;
		managementRun = 1'b1;
		mgmtRead(`MGMT_REG_BASE + 16'd12, value);
		checkValue("read data while running", value, 32'h0);
		while (selfFetches < 2)
			@(posedge clk);
		#5;
		managementRun = 1'b0;
		quiet = 0;
		while (quiet < 3) begin
			@(posedge clk);
			#5;
			if (!memoryReadEnable && !memoryWriteEnable)
				quiet++;
			else
				quiet = 0;
		end
		mgmtRead(`MGMT_REG_BASE + 16'd12, value);
		checkValue("loop sum in x3", value, 32'd15);
		mgmtRead(`MGMT_REG_BASE, value);
		checkValue("x0 after JAL to self", value, 32'h0);
		mgmtRead(`MGMT_PC_SET, value);
		checkValue("PC after run", value, LOOP_END);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		memoryBusy = 1'b0;
		managementRun = 1'b0;
		managementWriteEnable = 1'b0;
		managementAddress = '0;
		managementWriteData = '0;
		lfsr = 32'h07cf255b;
		cycles = 0;
		checks = 0;
		errors = 0;
		selfFetches = 0;
		for (int w = 0; w < 256; w++)
			mem[w] = {w[7:0] ^ 8'h5c, ~w[7:0], w[7:0], 8'h13};
		buildTable();
		cycleLimit = tInstr.size() * 40 + 600;
		resetCore();
		mgmtChecks();
		for (int i = 0; i < tInstr.size(); i++)
			runTableEntry(i);
		runLoopProgram();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+src
src/rvPkg.sv
src/instrDecoder.sv
src/aluUnit.sv
src/loadStoreUnit.sv
src/regFile.sv
src/coreControl.sv
src/rv32Core.sv
verification/rv32Core_assertions.sv
verification/rv32Core_tb.sv

/* Bender.yml */
package:
  name: rv32core

sources:
  - include_dirs:
      - src
    files:
      - src/rvPkg.sv
      - src/instrDecoder.sv
      - src/aluUnit.sv
      - src/loadStoreUnit.sv
      - src/regFile.sv
      - src/coreControl.sv
      - src/rv32Core.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/rv32Core_assertions.sv
      - verification/rv32Core_tb.sv
